// ==== hw/bank_arbiter.sv ====
/* Round-robin arbiter for one TCDM bank
   Serves one of the cores or the DMA per cycle */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module bank_arbiter
  import tcdm_pkg::*;
#(
  parameter int unsigned BankIdx = 0
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  tcdm_req_t [`TCDM_NUM_INI-1:0]       ini_req_i,
  input  logic      [`TCDM_NUM_INI-1:0]       ini_valid_i,
  output bank_req_t                           bank_req_o,
  output logic                                bank_valid_o,
  output logic      [`TCDM_NUM_INI-1:0]       grant_o
);

  logic [`TCDM_NUM_INI-1:0] hit;
  ini_t                     rr_q;
  ini_t                     win;
  logic                     found;

  // Which initiators want this bank
  always_comb begin
    for (int unsigned i = 0; i < `TCDM_NUM_INI; i++) begin
      hit[i] = ini_valid_i[i] &&
               (ini_req_i[i].addr[BankSelW-1:0] == BankSelW'(BankIdx));
    end
  end

  // ----------------------------------------
  // Pick, starting at the pointer
  // ----------------------------------------
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    win   = '0;
    for (int unsigned k = 0; k < `TCDM_NUM_INI; k++) begin
      idx = (int'(rr_q) + k) % `TCDM_NUM_INI;
      if (!found && hit[idx]) begin
        found = 1'b1;
        win   = ini_t'(idx);
      end
    end
  end

  assign grant_o      = found ? (`TCDM_NUM_INI)'(1) << win : '0;
  assign bank_valid_o = found;

  assign bank_req_o.row   = ini_req_i[win].addr[BankSelW +: RowW];
  assign bank_req_o.wen   = ini_req_i[win].wen;
  assign bank_req_o.wdata = ini_req_i[win].wdata;
  assign bank_req_o.ini   = win;

  // Pointer moves just past the winner
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= '0;
    end else if (found) begin
      if (win == ini_t'(`TCDM_NUM_INI - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= win + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/dma_ctrl.sv ====
/* Simplified TCDM DMA
   Copies a block word by word as read then write requests */

`timescale 1ns/1ps
`default_nettype none

module dma_ctrl
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       dma_start_i,
  input  dma_cfg_t   dma_cfg_i,
  output tcdm_req_t  req_o,
  output logic       req_valid_o,
  input  logic       req_ready_i,
  input  tcdm_resp_t resp_i,
  input  logic       resp_valid_i,
  output logic       dma_busy_o,
  output logic       dma_done_o
);

  dma_state_e state_q, state_d;
  addr_t      src_q, src_d;
  addr_t      dst_q, dst_d;
  len_t       cnt_q, cnt_d;
  logic       done_q, done_d;
  data_t      data_q;

  // ----------------------------------------
  // Copy FSM
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    src_d       = src_q;
    dst_d       = dst_q;
    cnt_d       = cnt_q;
    done_d      = 1'b0;
    req_valid_o = 1'b0;
    req_o       = '{addr: src_q, wen: 1'b0, wdata: '0};

    unique case (state_q)
      DMA_IDLE: begin
        if (dma_start_i) begin
          src_d = dma_cfg_i.src;
          dst_d = dma_cfg_i.dst;
          cnt_d = dma_cfg_i.len;
          // Empty job ends right away
          if (dma_cfg_i.len == '0) begin
            done_d = 1'b1;
          end else begin
            state_d = DMA_READ;
          end
        end
      end
      DMA_READ: begin
        req_valid_o = 1'b1;
        if (req_ready_i) begin
          state_d = DMA_WAIT;
        end
      end
      DMA_WAIT: begin
        if (resp_valid_i) begin
          state_d = DMA_WRITE;
        end
      end
      DMA_WRITE: begin
        req_valid_o = 1'b1;
        req_o       = '{addr: dst_q, wen: 1'b1, wdata: data_q};
        if (req_ready_i) begin
          state_d = DMA_ACK;
        end
      end
      DMA_ACK: begin
        if (resp_valid_i) begin
          src_d = src_q + 1'b1;
          dst_d = dst_q + 1'b1;
          cnt_d = cnt_q - 1'b1;
          if (cnt_q == len_t'(1)) begin
            state_d = DMA_IDLE;
            done_d  = 1'b1;
          end else begin
            state_d = DMA_READ;
          end
        end
      end
      default: state_d = DMA_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= DMA_IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      src_q   <= src_d;
      dst_q   <= dst_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  // Word in flight between read and write
  always_ff @(posedge clk_i) begin
    if (state_q == DMA_WAIT && resp_valid_i) begin
      data_q <= resp_i.rdata;
    end
  end

  assign dma_busy_o = (state_q != DMA_IDLE);
  assign dma_done_o = done_q;

endmodule

`default_nettype wire

// ==== hw/resp_router.sv ====
/* Routes grants and bank responses back to the initiators
   Purely combinational */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module resp_router
  import tcdm_pkg::*;
(
  input  logic       [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_INI-1:0] grant_i,
  input  bank_resp_t [`TCDM_NUM_BANKS-1:0]                    bank_resp_i,
  output logic       [`TCDM_NUM_INI-1:0]                      ini_ready_o,
  output tcdm_resp_t [`TCDM_NUM_INI-1:0]                      ini_resp_o,
  output logic       [`TCDM_NUM_INI-1:0]                      ini_resp_valid_o
);

  // ----------------------------------------
  // Ready from any bank grant
  // ----------------------------------------
  always_comb begin
    ini_ready_o = '0;
    for (int unsigned b = 0; b < `TCDM_NUM_BANKS; b++) begin
      ini_ready_o = ini_ready_o | grant_i[b];
    end
  end

  // ----------------------------------------
  // Response steering by tag
  // ----------------------------------------
  // At most one bank answers a given initiator per cycle
  always_comb begin
    ini_resp_valid_o = '0;
    ini_resp_o       = '0;
    for (int unsigned b = 0; b < `TCDM_NUM_BANKS; b++) begin
      if (bank_resp_i[b].valid) begin
        ini_resp_valid_o[bank_resp_i[b].ini] = 1'b1;
        ini_resp_o[bank_resp_i[b].ini].rdata = bank_resp_i[b].rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcdm_bank.sv ====
/* One TCDM SRAM bank
   Single-cycle read, tags each response with its initiator */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  bank_req_t  bank_req_i,
  input  logic       bank_valid_i,
  output bank_resp_t bank_resp_o
);

  data_t mem_q [`TCDM_ROWS];
  data_t rdata_q;
  logic  valid_q;
  ini_t  ini_q;

  // Storage and read port
  always_ff @(posedge clk_i) begin
    if (bank_valid_i) begin
      if (bank_req_i.wen) begin
        mem_q[bank_req_i.row] <= bank_req_i.wdata;
      end
      // Writes answer with zero
      rdata_q <= bank_req_i.wen ? '0 : mem_q[bank_req_i.row];
    end
  end

  // Response tracking
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      ini_q   <= '0;
    end else begin
      valid_q <= bank_valid_i;
      if (bank_valid_i) begin
        ini_q <= bank_req_i.ini;
      end
    end
  end

  assign bank_resp_o.valid = valid_q;
  assign bank_resp_o.ini   = ini_q;
  assign bank_resp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/tcdm_group.sv ====
/* Top of the TCDM group
   Four cores and a DMA share four interleaved banks */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module tcdm_group
  import tcdm_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Core request ports
  input  tcdm_req_t  [`TCDM_NUM_CORES-1:0]    core_req_i,
  input  logic       [`TCDM_NUM_CORES-1:0]    core_req_valid_i,
  output logic       [`TCDM_NUM_CORES-1:0]    core_req_ready_o,
  output tcdm_resp_t [`TCDM_NUM_CORES-1:0]    core_resp_o,
  output logic       [`TCDM_NUM_CORES-1:0]    core_resp_valid_o,
  // DMA control
  input  logic                                dma_start_i,
  input  dma_cfg_t                            dma_cfg_i,
  output logic                                dma_busy_o,
  output logic                                dma_done_o
);

  tcdm_req_t  dma_req;
  logic       dma_req_valid;
  tcdm_resp_t dma_resp;

  tcdm_req_t  [`TCDM_NUM_INI-1:0] ini_req;
  logic       [`TCDM_NUM_INI-1:0] ini_valid;
  logic       [`TCDM_NUM_INI-1:0] ini_ready;
  tcdm_resp_t [`TCDM_NUM_INI-1:0] ini_resp;
  logic       [`TCDM_NUM_INI-1:0] ini_resp_valid;

  bank_req_t  [`TCDM_NUM_BANKS-1:0]                    bank_req;
  logic       [`TCDM_NUM_BANKS-1:0]                    bank_valid;
  logic       [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_INI-1:0] grant;
  bank_resp_t [`TCDM_NUM_BANKS-1:0]                    bank_resp;

  // DMA sits above the cores
  assign ini_req   = {dma_req, core_req_i};
  assign ini_valid = {dma_req_valid, core_req_valid_i};

  assign core_req_ready_o  = ini_ready[`TCDM_NUM_CORES-1:0];
  assign core_resp_o       = ini_resp[`TCDM_NUM_CORES-1:0];
  assign core_resp_valid_o = ini_resp_valid[`TCDM_NUM_CORES-1:0];
  assign dma_resp          = ini_resp[`TCDM_NUM_CORES];

  // ----------------------------------------
  // Banks
  // ----------------------------------------
  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_banks
    bank_arbiter #(
      .BankIdx(b)
    ) i_arbiter (
      .clk_i       (clk_i        ),
      .arst_n_i    (arst_n_i     ),
      .ini_req_i   (ini_req      ),
      .ini_valid_i (ini_valid    ),
      .bank_req_o  (bank_req[b]  ),
      .bank_valid_o(bank_valid[b]),
      .grant_o     (grant[b]     )
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i        ),
      .arst_n_i    (arst_n_i     ),
      .bank_req_i  (bank_req[b]  ),
      .bank_valid_i(bank_valid[b]),
      .bank_resp_o (bank_resp[b] )
    );
  end

  resp_router i_router (
    .grant_i         (grant         ),
    .bank_resp_i     (bank_resp     ),
    .ini_ready_o     (ini_ready     ),
    .ini_resp_o      (ini_resp      ),
    .ini_resp_valid_o(ini_resp_valid)
  );

  // ----------------------------------------
  // DMA
  // ----------------------------------------
  dma_ctrl i_dma (
    .clk_i       (clk_i                          ),
    .arst_n_i    (arst_n_i                       ),
    .dma_start_i (dma_start_i                    ),
    .dma_cfg_i   (dma_cfg_i                      ),
    .req_o       (dma_req                        ),
    .req_valid_o (dma_req_valid                  ),
    .req_ready_i (ini_ready[`TCDM_NUM_CORES]     ),
    .resp_i      (dma_resp                       ),
    .resp_valid_i(ini_resp_valid[`TCDM_NUM_CORES]),
    .dma_busy_o  (dma_busy_o                     ),
    .dma_done_o  (dma_done_o                     )
  );

endmodule

`default_nettype wire

// ==== hw/tcdm_params.svh ====
/* Group dimensions and widths for the TCDM group model */

`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// ----------------------------------------
// Initiators
// ----------------------------------------
`define TCDM_NUM_CORES 4
// Cores plus one DMA
`define TCDM_NUM_INI 5

// ----------------------------------------
// Memory
// ----------------------------------------
`define TCDM_NUM_BANKS 4
`define TCDM_ROWS 64
// Word addressed
`define TCDM_ADDR_W 8
`define TCDM_DATA_W 32
`define TCDM_LEN_W 8

`endif

// ==== hw/tcdm_pkg.sv ====
/* Shared types of the TCDM group
   Request and response structs, DMA job and FSM states */

`default_nettype none

`include "tcdm_params.svh"

package tcdm_pkg;

  localparam int unsigned BankSelW = $clog2(`TCDM_NUM_BANKS);
  localparam int unsigned RowW     = $clog2(`TCDM_ROWS);
  localparam int unsigned IniW     = $clog2(`TCDM_NUM_INI);

  typedef logic [`TCDM_ADDR_W-1:0] addr_t;
  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [RowW-1:0]         row_t;
  typedef logic [IniW-1:0]         ini_t;
  typedef logic [`TCDM_LEN_W-1:0]  len_t;

  // Initiator side
  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // Bank side, tagged with the initiator
  typedef struct packed {
    row_t  row;
    logic  wen;
    data_t wdata;
    ini_t  ini;
  } bank_req_t;

  typedef struct packed {
    logic  valid;
    ini_t  ini;
    data_t rdata;
  } bank_resp_t;

  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } dma_cfg_t;

  typedef enum logic [2:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WAIT,
    DMA_WRITE,
    DMA_ACK
  } dma_state_e;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the TCDM group testbench with Verilator, run it, and look for the pass line
verilator --binary -f verilog.f --top-module tb_tcdm_group -o tb_tcdm_group \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_tcdm_group > sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== verif/tb_tcdm_group.sv ====
/* Testbench for the TCDM group
   Fills the memory, then replays a trace of core and DMA operations against a shadow copy */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module tb_tcdm_group
  import tcdm_pkg::*;
();

  localparam int ClkPeriod = 100;
  localparam int Cores     = `TCDM_NUM_CORES;
  localparam int Words     = `TCDM_NUM_BANKS * `TCDM_ROWS;

  typedef enum logic [7:0] {
    OP_WRITE = 8'h0,
    OP_READ  = 8'h1,
    OP_PAR   = 8'h2,
    OP_DMA   = 8'h3,
    OP_IDLE  = 8'h4
  } op_e;

  // For a DMA the port field holds the length
  typedef struct packed {
    op_e        op;
    logic [7:0] port;
    addr_t      addr;
    data_t      data;
  } trace_t;

  logic                     clk;
  logic                     arst_n;
  tcdm_req_t  [Cores-1:0]   core_req;
  logic       [Cores-1:0]   core_valid;
  logic       [Cores-1:0]   core_ready;
  tcdm_resp_t [Cores-1:0]   core_resp;
  logic       [Cores-1:0]   core_resp_valid;
  logic                     dma_start;
  dma_cfg_t                 dma_cfg;
  logic                     dma_busy;
  logic                     dma_done;

  data_t       shadow [Words];
  trace_t      trace_q [$];
  dma_cfg_t    dma_job;
  int          trace_len     = 0;
  logic        trace_ready   = 1'b0;
  int          check_count   = 0;
  int          err_count     = 0;
  int          mon_err_count = 0;
  int          dma_count     = 0;
  int          done_count    = 0;
  logic        job_pending   = 1'b0;
  logic        dma_run       = 1'b0;
  logic        done_prev     = 1'b0;
  logic        start_seen;
  int unsigned lcg_state     = 32'hbc8;

  tcdm_group i_dut (
    .clk_i            (clk            ),
    .arst_n_i         (arst_n         ),
    .core_req_i       (core_req       ),
    .core_req_valid_i (core_valid     ),
    .core_req_ready_o (core_ready     ),
    .core_resp_o      (core_resp      ),
    .core_resp_valid_o(core_resp_valid),
    .dma_start_i      (dma_start      ),
    .dma_cfg_i        (dma_cfg        ),
    .dma_busy_o       (dma_busy       ),
    .dma_done_o       (dma_done       )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // Core access driver
  // ----------------------------------------
  task automatic run_accesses(input logic [Cores-1:0] act, input tcdm_req_t req [Cores],
                              input data_t exp [Cores]);
    logic [Cores-1:0] pend;
    logic [Cores-1:0] acc;
    int               waited [Cores];
    pend = act;
    for (int p = 0; p < Cores; p++) begin
      waited[p]   = 0;
      core_req[p] = req[p];
    end
    core_valid = act;
    while (pend != '0) begin
      // Ready settles well before the rising edge
      #(ClkPeriod / 4);
      check_value("ready without valid", data_t'(core_ready & ~core_valid), '0);
      acc  = pend & core_ready;
      pend = pend & ~core_ready;
      @(negedge clk);
      check_value("response valid", data_t'(core_resp_valid), data_t'(acc));
      for (int p = 0; p < Cores; p++) begin
        if (acc[p]) begin
          check_value($sformatf("core %0d response data", p), core_resp[p].rdata, exp[p]);
          check_count++;
          assert (waited[p] < `TCDM_NUM_INI) else begin
            err_count++;
            $display("Fail at %0d ns: core %0d waited %0d cycles for a grant",
                     $time, p, waited[p]);
          end
        end else if (pend[p]) begin
          waited[p]++;
        end
      end
      core_valid = pend;
    end
  endtask

  task automatic single_access(input int port, input logic wen, input addr_t addr,
                               input data_t wdata, input data_t exp);
    logic [Cores-1:0] act;
    tcdm_req_t        req [Cores];
    data_t            exp_all [Cores];
    act = '0;
    for (int p = 0; p < Cores; p++) begin
      req[p]     = '0;
      exp_all[p] = '0;
    end
    act[port]     = 1'b1;
    req[port]     = '{addr: addr, wen: wen, wdata: wdata};
    exp_all[port] = exp;
    run_accesses(act, req, exp_all);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      check_value("stray response valid", data_t'(core_resp_valid), '0);
    end
  endtask

  task automatic check_idle();
    @(negedge clk);
    check_value("ready while idle", data_t'(core_ready), '0);
    check_value("response valid while idle", data_t'(core_resp_valid), '0);
    check_value("DMA busy while idle", data_t'(dma_busy), '0);
    check_value("DMA done while idle", data_t'(dma_done), '0);
  endtask

  // Write then read back every word, rotating cores so each core meets each bank
  task automatic fill_memory();
    data_t word;
    int    port;
    for (int a = 0; a < Words; a++) begin
      word      = lcg_next();
      shadow[a] = word;
      port      = (a + a / `TCDM_NUM_BANKS) % Cores;
      single_access(port, 1'b1, addr_t'(a), word, '0);
      single_access((port + 1) % Cores, 1'b0, addr_t'(a), '0, word);
      idle_cycles(int'(lcg_next() % 3));
    end
  endtask

  // ----------------------------------------
  // DMA jobs
  // ----------------------------------------
  task automatic start_dma(input trace_t t);
    dma_job   = '{src: t.addr, dst: t.data[`TCDM_ADDR_W-1:0], len: t.port};
    dma_cfg   = dma_job;
    dma_start = 1'b1;
    @(negedge clk);
    dma_start   = 1'b0;
    dma_count++;
    job_pending = 1'b1;
  endtask

  task automatic complete_dma();
    int n;
    int src;
    int dst;
    if (job_pending) begin
      wait (done_count == dma_count);
      src = int'(dma_job.src);
      dst = int'(dma_job.dst);
      // Word by word upward, as the engine copies
      for (int k = 0; k < int'(dma_job.len); k++) begin
        shadow[(dst + k) % Words] = shadow[(src + k) % Words];
      end
      // An empty job leaves its destination word alone
      n = (dma_job.len == '0) ? 1 : int'(dma_job.len);
      for (int k = 0; k < n; k++) begin
        single_access(k % Cores, 1'b0, addr_t'(dst + k), '0, shadow[(dst + k) % Words]);
      end
      job_pending = 1'b0;
    end
    check_idle();
  endtask

  always_ff @(posedge clk) begin
    start_seen <= dma_start && (dma_cfg.len != '0);
  end

  // Busy from the cycle after a start until the done pulse
  always @(negedge clk) begin
    if (start_seen) dma_run = 1'b1;
    if (dma_done) begin
      done_count++;
      dma_run = 1'b0;
      assert (!done_prev) else begin
        mon_err_count++;
        $display("Fail at %0d ns: DMA done pulse longer than one cycle", $time);
      end
    end else begin
      assert (dma_busy == dma_run) else begin
        mon_err_count++;
        $display("Fail at %0d ns: DMA busy is %0b, expected %0b", $time, dma_busy, dma_run);
      end
    end
    done_prev = dma_done;
  end

  // ----------------------------------------
  // Trace
  // ----------------------------------------
  task automatic load_trace();
    int    fd;
    int    op_v;
    int    port_v;
    int    addr_v;
    int    data_v;
    string line;
    fd = $fopen("verif/tcdm_trace.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("Could not open the trace file verif/tcdm_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h", op_v, port_v, addr_v, data_v) == 4) begin
            trace_q.push_back('{op: op_e'(op_v[7:0]), port: port_v[7:0],
                                addr: addr_v[7:0], data: data_v});
          end
        end
      end
      $fclose(fd);
    end
    trace_len = trace_q.size();
    if (trace_len == 0) begin
      err_count++;
      $display("The trace file holds no operations");
    end
    trace_ready = 1'b1;
  endtask

  initial begin
    wait (trace_ready);
    #(ClkPeriod * (trace_len * 200 + Words * 8));
    $display("Timeout: the run did not complete in the allowed time");
    $display("tests failed");
    $finish;
  end

  initial begin
    trace_t           t;
    logic [Cores-1:0] act;
    tcdm_req_t        req [Cores];
    data_t            exp [Cores];
    int               i;
    int               j;
    arst_n     = 1'b0;
    core_req   = '0;
    core_valid = '0;
    dma_start  = 1'b0;
    dma_cfg    = '0;
    load_trace();
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    check_idle();
    fill_memory();
    i = 0;
    while (i < trace_len) begin
      t = trace_q[i];
      case (t.op)
        OP_WRITE: begin
          shadow[t.addr] = t.data;
          single_access(int'(t.port), 1'b1, t.addr, t.data, '0);
        end
        OP_READ: single_access(int'(t.port), 1'b0, t.addr, '0, t.data);
        OP_PAR: begin
          act = '0;
          for (int p = 0; p < Cores; p++) begin
            req[p] = '0;
            exp[p] = '0;
          end
          // One read per core, issued together
          j = i;
          while (j < trace_len && trace_q[j].op == OP_PAR) begin
            act[trace_q[j].port] = 1'b1;
            req[trace_q[j].port] = '{addr: trace_q[j].addr, wen: 1'b0, wdata: '0};
            exp[trace_q[j].port] = trace_q[j].data;
            j++;
          end
          i = j - 1;
          run_accesses(act, req, exp);
        end
        OP_DMA:  start_dma(t);
        OP_IDLE: complete_dma();
        default: begin
          err_count++;
          $display("Unknown opcode %0h in trace entry %0d", t.op, i);
        end
      endcase
      idle_cycles(int'(lcg_next() % 3));
      i++;
    end
    $display("Checks %0d, errors %0d, DMA monitor errors %0d",
             check_count, err_count, mon_err_count);
    if (err_count == 0 && mon_err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tcdm_trace.txt ====
# op port addr data, all hex; op 0 write, 1 read, 2 parallel read group, 3 DMA, 4 check idle
# For a DMA the port column is the length, addr the source and data the destination
0 0 10 a5a50010
0 1 14 11110014
0 2 18 22220018
0 3 1c 3333001c
0 0 21 5a5a0021
0 1 32 c3c30032
0 2 43 3c3c0043
1 3 21 5a5a0021
1 2 10 a5a50010
2 0 1c 3333001c
2 1 18 22220018
2 2 14 11110014
2 3 10 a5a50010
4 0 00 00000000
2 0 21 5a5a0021
2 1 32 c3c30032
2 2 43 3c3c0043
2 3 10 a5a50010
3 08 80 000000c0
1 0 10 a5a50010
1 1 32 c3c30032
4 0 00 00000000
3 00 90 000000d0
4 0 00 00000000

// ==== verilog.f ====
+incdir+hw
hw/tcdm_pkg.sv
hw/bank_arbiter.sv
hw/tcdm_bank.sv
hw/resp_router.sv
hw/dma_ctrl.sv
hw/tcdm_group.sv
verif/tb_tcdm_group.sv
